//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef enum logic [2:0] {
		cls_op_imm,
		cls_op_reg,
		cls_lui,
		cls_load,
		cls_store,
		cls_ebreak,
		cls_illegal
	} inst_class_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b	// lui
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch_setup,
		st_fetch_access,
		st_execute,
		st_mem_setup,
		st_mem_access,
		st_halt
	} ctrl_state_e;

	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_system = 7'b1110011;

endpackage

`default_nettype wire

//--- hdl/dec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_if import rv_pkg::*; ();

	inst_class_e iclass;
	alu_op_e     alu_op;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] imm;	// final form, no further extension
	logic        use_imm;

	modport dec (
		output iclass, alu_op, rs1, rs2, rd, imm, use_imm
	);

	modport exe (
		input alu_op, rs1, rs2, rd, imm, use_imm
	);

	// control only needs to know what kind of instruction it is
	modport ctl (
		input iclass
	);

endinterface

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  alu_op_e     op,
	output logic [31:0] res
);

	logic [4:0] shamt;

	assign shamt = b[4:0];	// rv32 shift amount

	always_comb begin
		case (op)
			alu_add:    res = a + b;
			alu_sub:    res = a - b;
			alu_sll:    res = a << shamt;
			alu_slt:    res = {31'b0, $signed(a) < $signed(b)};
			alu_sltu:   res = {31'b0, a < b};
			alu_xor:    res = a ^ b;
			alu_srl:    res = a >> shamt;
			alu_sra:    res = $unsigned($signed(a) >>> shamt);
			alu_or:     res = a | b;
			alu_and:    res = a & b;
			alu_pass_b: res = b;
			default:    res = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/idu.sv
`timescale 1ns/1ps
`default_nettype none

module idu import rv_pkg::*; (
	input logic [31:0] inst,
	dec_if.dec         dec_bus
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_u;

	// funct3 picks the operation and alt is funct7 bit 5 where it counts
	function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  f3_op = alt ? alu_sub : alu_add;
			3'b001:  f3_op = alu_sll;
			3'b010:  f3_op = alu_slt;
			3'b011:  f3_op = alu_sltu;
			3'b100:  f3_op = alu_xor;
			3'b101:  f3_op = alt ? alu_sra : alu_srl;
			3'b110:  f3_op = alu_or;
			default: f3_op = alu_and;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	assign dec_bus.rs1 = inst[19:15];
	assign dec_bus.rs2 = inst[24:20];
	assign dec_bus.rd  = inst[11:7];

	always_comb begin
		dec_bus.iclass  = cls_illegal;
		dec_bus.alu_op  = alu_add;
		dec_bus.imm     = imm_i;
		dec_bus.use_imm = 1'b1;
		case (opcode)
			opc_op_imm: begin
				// addi must not turn into a subtract on a negative immediate
				dec_bus.alu_op = f3_op(funct3, (funct3 == 3'b101) && inst[30]);
				if (funct3 == 3'b001)
					dec_bus.iclass = (funct7 == 7'b0000000) ? cls_op_imm : cls_illegal;
				else if (funct3 == 3'b101)
					dec_bus.iclass = (funct7 == 7'b0000000 || funct7 == 7'b0100000) ?
						cls_op_imm : cls_illegal;
				else
					dec_bus.iclass = cls_op_imm;
			end
			opc_op: begin
				dec_bus.use_imm = 1'b0;
				dec_bus.alu_op  = f3_op(funct3, inst[30]);
				if (funct7 == 7'b0000000)
					dec_bus.iclass = cls_op_reg;
				else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
					dec_bus.iclass = cls_op_reg;	// sub, sra
			end
			opc_lui: begin
				dec_bus.iclass = cls_lui;
				dec_bus.alu_op = alu_pass_b;
				dec_bus.imm    = imm_u;
			end
			opc_load: begin
				if (funct3 == 3'b010)
					dec_bus.iclass = cls_load;	// lw only
			end
			opc_store: begin
				dec_bus.imm = imm_s;
				if (funct3 == 3'b010)
					dec_bus.iclass = cls_store;
			end
			opc_system: begin
				// ebreak is the one exact word accepted here
				if (inst[31:20] == 12'd1 && inst[19:7] == 13'd0)
					dec_bus.iclass = cls_ebreak;
			end
			default: dec_bus.iclass = cls_illegal;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
	input  logic        clk,
	input  logic        rst_n,
	dec_if.exe          dec_bus,
	input  logic        wb_en,
	input  logic        wb_load,
	input  logic [31:0] load_data,
	output logic [31:0] alu_res,
	output logic [31:0] rs2_val
);

	// x0 is not stored
	logic [31:0] regs [1:31];
	logic [31:0] rs1_val;
	logic [31:0] opb;
	logic [31:0] wb_data;

	assign rs1_val = (dec_bus.rs1 == 5'd0) ? 32'b0 : regs[dec_bus.rs1];
	assign rs2_val = (dec_bus.rs2 == 5'd0) ? 32'b0 : regs[dec_bus.rs2];

	assign opb = dec_bus.use_imm ? dec_bus.imm : rs2_val;

	alu u_alu (
		.a   (rs1_val),
		.b   (opb),
		.op  (dec_bus.alu_op),
		.res (alu_res)
	);

	assign wb_data = wb_load ? load_data : alu_res;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= 32'b0;
			end
		end else if (wb_en && dec_bus.rd != 5'd0) begin
			regs[dec_bus.rd] <= wb_data;	// writes to x0 dropped
		end
	end

endmodule

`default_nettype wire

//--- hdl/ifu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_ctrl import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	dec_if.ctl          dec_bus,
	input  logic [31:0] alu_res,
	input  logic [31:0] rs2_val,
	output logic [31:0] inst,
	output logic        wb_en,
	output logic        wb_load,
	output logic [31:0] load_data,
	output logic        halted,
	output logic        illegal,
	output logic [31:0] paddr,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] pwdata,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic        pslverr
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	logic [31:0] pc;
	logic        run;	// low for the first cycle out of reset
	logic        mem_phase;
	logic        is_store;
	logic        step_pc;
	logic        set_illegal;

	assign mem_phase = (state == st_mem_setup) || (state == st_mem_access);
	assign is_store  = (dec_bus.iclass == cls_store);

	// apb outputs held by state, pc and registers while waiting
	assign psel    = run && (state != st_execute) && (state != st_halt);
	assign penable = (state == st_fetch_access) || (state == st_mem_access);
	assign pwrite  = mem_phase && is_store;
	assign paddr   = mem_phase ? alu_res : pc;
	assign pwdata  = rs2_val;

	assign load_data = prdata;
	assign halted    = (state == st_halt);

	always_comb begin
		state_nxt   = state;
		step_pc     = 1'b0;
		set_illegal = 1'b0;
		wb_en       = 1'b0;
		wb_load     = 1'b0;
		case (state)
			st_fetch_setup: begin
				if (run)
					state_nxt = st_fetch_access;
			end
			st_fetch_access: begin
				if (pready && pslverr) begin
					state_nxt   = st_halt;
					set_illegal = 1'b1;
				end else if (pready) begin
					state_nxt = st_execute;
				end
			end
			st_execute: begin
				case (dec_bus.iclass)
					cls_op_imm, cls_op_reg, cls_lui: begin
						wb_en     = 1'b1;
						step_pc   = 1'b1;
						state_nxt = st_fetch_setup;
					end
					cls_load, cls_store: state_nxt = st_mem_setup;
					cls_ebreak:          state_nxt = st_halt;
					default: begin
						state_nxt   = st_halt;
						set_illegal = 1'b1;
					end
				endcase
			end
			st_mem_setup: state_nxt = st_mem_access;
			st_mem_access: begin
				if (pready && pslverr) begin
					state_nxt   = st_halt;
					set_illegal = 1'b1;
				end else if (pready) begin
					wb_en     = !is_store;	// load writes at the pready edge
					wb_load   = !is_store;
					step_pc   = 1'b1;
					state_nxt = st_fetch_setup;
				end
			end
			default: state_nxt = st_halt;	// halt is final
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_fetch_setup;
			pc      <= RESET_PC;
			run     <= 1'b0;
			illegal <= 1'b0;
		end else begin
			state <= state_nxt;
			run   <= 1'b1;
			if (step_pc)
				pc <= pc + 32'd4;
			if (set_illegal)
				illegal <= 1'b1;	// sticky
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch_access && pready)
			inst <= prdata;
	end

endmodule

`default_nettype wire

//--- hdl/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
	parameter logic [31:0] RESET_PC = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	output logic [31:0] paddr,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] pwdata,
	input  logic [31:0] prdata,
	input  logic        pready,
	input  logic        pslverr,
	output logic        halted,
	output logic        illegal
);

	logic [31:0] inst;
	logic [31:0] alu_res;
	logic [31:0] rs2_val;
	logic        wb_en;
	logic        wb_load;
	logic [31:0] load_data;

	dec_if u_dec_if ();

	idu u_idu (
		.inst    (inst),
		.dec_bus (u_dec_if.dec)
	);

	exu u_exu (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec_bus   (u_dec_if.exe),
		.wb_en     (wb_en),
		.wb_load   (wb_load),
		.load_data (load_data),
		.alu_res   (alu_res),
		.rs2_val   (rs2_val)
	);

	ifu_ctrl #(
		.RESET_PC (RESET_PC)
	) u_ifu_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec_bus   (u_dec_if.ctl),
		.alu_res   (alu_res),
		.rs2_val   (rs2_val),
		.inst      (inst),
		.wb_en     (wb_en),
		.wb_load   (wb_load),
		.load_data (load_data),
		.halted    (halted),
		.illegal   (illegal),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

endmodule

`default_nettype wire

//--- test/rv_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
	input logic        clk,
	input logic        rst_n,
	input logic        psel,
	input logic        penable,
	input logic        pready,
	input logic        pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	input logic        halted,
	input logic        illegal
);

	// setup lasts one cycle and the address phase carries over
	setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
		psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwrite))
		else $error("apb setup not followed by access with the same address");

	wait_stable: assert property (@(posedge clk) disable iff (!rst_n)
		psel && penable && !pready |=>
			psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
		else $error("apb signals changed while pready was low");

	no_bus_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !psel && !penable)
		else $error("apb transfer started after halt");

	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted && $stable(illegal))
		else $error("halt state or its cause changed");

endmodule

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam int mem_words  = 128;
	localparam int res_base   = 'h60;	// expected results in the image
	localparam int run2_base  = 'h50;
	localparam int max_cycles = 3000;

	logic        clk;
	logic        rst_n   = 1'b0;
	logic [31:0] prdata  = 32'b0;
	logic        pready  = 1'b0;
	logic        pslverr = 1'b0;
	logic [31:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic        halted;
	logic        illegal;

	logic [31:0] mem [0:mem_words-1];
	logic [31:0] lfsr      = 32'd92114;
	logic [1:0]  wait_left = 2'd0;
	int          region    = 0;	// word offset of the program being run
	int          bus_errs  = 0;
	int          errs;
	int          passes;
	logic [31:0] wr_addr [$];
	logic [31:0] wr_data [$];

	tb_clock u_clock (.clk(clk));

	rv_core_top #(
		.RESET_PC (32'h0)
	) dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.halted  (halted),
		.illegal (illegal)
	);

	bind rv_core_top rv_core_checker u_checker (.*);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// apb slave memory with 0 to 3 random wait states
	always @(posedge clk) begin
		logic [31:0] s1;
		logic [31:0] s2;
		int          idx;
		idx = region + int'(paddr[31:2]);
		if (!rst_n) begin
			pready <= 1'b0;
		end else if (psel && !penable) begin
			s1 = lfsr_next(lfsr);
			s2 = lfsr_next(s1);
			lfsr      <= s2;
			wait_left <= {s2[0], s1[0]};
			pready    <= ({s2[0], s1[0]} == 2'd0);
			if (idx >= mem_words) begin
				bus_errs++;
				$display("apb access at %h lies outside the memory model", paddr);
			end else if (!pwrite) begin
				prdata <= mem[idx];
			end
		end else if (psel && penable) begin
			if (pready) begin
				pready <= 1'b0;
				if (pwrite && idx < mem_words) begin
					mem[idx] <= pwdata;
					wr_addr.push_back(paddr);
					wr_data.push_back(pwdata);
				end
			end else begin
				wait_left <= wait_left - 2'd1;
				pready    <= (wait_left == 2'd1);
			end
		end
	end

	task automatic compare_addr(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act === exp) begin
			passes++;
			$display("ok    %s: addr %h", name, act);
		end else begin
			errs++;
			$display("Error %s: expected addr %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_data(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act === exp) begin
			passes++;
			$display("ok    %s: data %h", name, act);
		end else begin
			errs++;
			$display("Error %s: expected data %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act === exp) begin
			passes++;
			$display("ok    %s: %b", name, act);
		end else begin
			errs++;
			$display("Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_halt(input string name, output logic ok);
		int cyc;
		cyc = 0;
		while (!halted && cyc < max_cycles) begin
			@(negedge clk);
			cyc++;
		end
		ok = halted;
		if (!ok)
			$display("%s: core did not halt within %0d cycles", name, max_cycles);
	endtask

	// stores since index first against the table at tbl and then the illegal flag
	task automatic check_run(input string name, input int first, input int n_exp,
		input int tbl, input logic exp_illegal);
		compare_data({name, " store count"}, n_exp, wr_addr.size() - first);
		for (int i = 0; i < n_exp; i++) begin
			if (first + i < wr_addr.size()) begin
				compare_addr($sformatf("%s store %0d", name, i), mem[tbl + 2 * i],
					wr_addr[first + i]);
				compare_data($sformatf("%s store %0d", name, i), mem[tbl + 2 * i + 1],
					wr_data[first + i]);
			end
		end
		compare_flag({name, " illegal"}, exp_illegal, illegal);
	endtask

	initial begin
		int   first;
		int   n_st;
		int   flag_at;
		logic ok;
		errs   = 0;
		passes = 0;
		$readmemh("test/prog_input.mem", mem);
		n_st    = int'(mem[res_base]);
		flag_at = res_base + 1 + 2 * n_st;
		apply_reset();
		wait_halt("run 1", ok);
		if (ok) begin
			check_run("run 1", 0, n_st, res_base + 1, mem[flag_at][0]);
			region = run2_base;	// program with the illegal word
			first  = wr_addr.size();
			apply_reset();
			wait_halt("run 2", ok);
			if (ok)
				check_run("run 2", first, 0, 0, mem[flag_at + 1][0]);
		end
		$display("checks: %0d passed, %0d failed, %0d bus errors", passes, errs, bus_errs);
		if (ok && errs == 0 && bus_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/prog_input.mem
// hex words at @ word addresses: program, lw source, second program, then at @60
// the store count, store address and data pairs, and the illegal flag of run 1 and run 2
@00
00500093 FF408113 40115193 01C15213	// addi x1 5, addi x2 x1 -12, srai x3, srli x4
00409293 0F014313 03C37393 7013E413	// slli x5, xori x6, andi x7, ori x8
FFF12493 40208533 001125B3 00113633	// slti x9, sub x10, slt x11, sltu x12
401156B3 00115733 008347B3 00429833	// sra x13, srl x14, xor x15, sll x16
00E7F933 009968B3 123459B7 09002A03	// and x18, or x17, lui x19, lw x20 0x90(x0)
01498AB3 00708013 0A32A823 0A82AA23	// add x21, addi x0 x1 7, sw x3 0xb0(x5), sw x8
0B02AC23 0AA2AE23 0CB2A023 0CC2A223	// sw x16, sw x10, sw x11, sw x12
0CD2A423 0D12A623 0D52A823 12002223	// sw x13, sw x17, sw x21, sw x0 0x124(x0)
00100073	// ebreak
@24
00000ABC	// lw source
@50
00500093 02208033 00100073	// addi, mul (not rv32i), ebreak
@60
0000000A
00000100 FFFFFFFC 00000104 00000709
00000108 00280000 0000010C 0000000C
00000110 00000001 00000114 00000000
00000118 FFFFFFFF 0000011C 07FFF801
00000120 12345ABC 00000124 00000000
00000000 00000001

//--- rv_core.f
hdl/rv_pkg.sv
hdl/dec_if.sv
hdl/alu.sv
hdl/idu.sv
hdl/exu.sv
hdl/ifu_ctrl.sv
hdl/rv_core_top.sv
test/tb_clock.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o sim_rv_core; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_rv_core)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" <<< "$out"; then
	exit 0
fi
exit 1
